// ==== verilog/seq_config.svh ====
`ifndef SEQ_CONFIG_SVH
`define SEQ_CONFIG_SVH

// Build-time constants shared by the sequencer blocks

`define RESET_VECTOR 32'h0000_1000   // First fetch address

`define INSTR_STEP 32'd4              // Fixed 32-bit instruction size

`define DIV_CYCLES 32                 // One quotient bit per cycle

`endif

// ==== verilog/isa_pkg.sv ====
`default_nettype none

package isa_pkg;

  localparam logic [6:0] OPC_OP    = 7'b0110011;  // Register-register ALU and M ext
  localparam logic [6:0] OPC_LOAD  = 7'b0000011;
  localparam logic [6:0] OPC_STORE = 7'b0100011;

  typedef struct packed {
    logic [6:0] funct7;   // Also upper store immediate
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;       // Also lower store immediate
    logic [6:0] opcode;
  } r_fields_t;

  typedef struct packed {
    logic [11:0] imm;     // Load offset
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } i_fields_t;

  // One fetched word, seen as R or I format
  typedef union packed {
    r_fields_t r;
    i_fields_t i;
  } instr_u;

  typedef enum logic [5:0] {
    OP_ADD = 6'd0,  OP_SUB = 6'd1,  OP_SLL = 6'd2,   OP_SLT = 6'd3,
    OP_SLTU = 6'd4, OP_XOR = 6'd5,  OP_SRL = 6'd6,   OP_SRA = 6'd7,
    OP_OR = 6'd8,   OP_AND = 6'd9,  OP_MUL = 6'd10,  OP_MULH = 6'd11,
    OP_MULHSU = 6'd12, OP_MULHU = 6'd13,
    OP_DIV = 6'd14, OP_DIVU = 6'd15, OP_REM = 6'd16, OP_REMU = 6'd17,
    OP_LB = 6'd27,  OP_LH = 6'd28,  OP_LW = 6'd29,   OP_LBU = 6'd30,
    OP_LHU = 6'd31, OP_SB = 6'd32,  OP_SH = 6'd33,   OP_SW = 6'd34,
    OP_OTHER = 6'd63                                   // Anything not handled here
  } op_e;

  typedef enum logic [1:0] {
    CLS_PLAIN  = 2'd0,    // Done in one execute cycle
    CLS_DIVREM = 2'd1,    // Waits for divider
    CLS_MEM    = 2'd2     // Waits for bus dv
  } op_class_e;

  typedef enum logic [1:0] {
    SZ_BYTE = 2'd0,
    SZ_HALF = 2'd1,
    SZ_WORD = 2'd2
  } access_size_e;

endpackage

`default_nettype wire

// ==== verilog/core_pkg.sv ====
`default_nettype none

package core_pkg;

  typedef enum logic [1:0] {
    ST_FETCH   = 2'd0,
    ST_EXECUTE = 2'd1,
    ST_MINT    = 2'd2,    // Machine interrupt service
    ST_SINT    = 2'd3     // Supervisor interrupt service
  } ctrl_state_e;

  // Held stable until the memory answers with dv
  typedef struct packed {
    logic                  valid;
    logic                  write;
    isa_pkg::access_size_e size;
    logic [31:0]           addr;
    logic [31:0]           wdata;
  } bus_req_t;

  typedef struct packed {
    logic taken;          // One-cycle pulse on entry
    logic machine;        // Last cause, held
    logic supervisor;
  } trap_cause_t;

endpackage

`default_nettype wire

// ==== verilog/mem_port.sv ====
`default_nettype none

`include "seq_config.svh"

module mem_port (
  input  wire logic                  i_clk,
  input  wire logic                  i_reset,
  input  wire logic                  i_start_fetch,
  input  wire logic                  i_start_mem,
  input  wire logic                  i_load_pc,
  input  wire logic [31:0]           i_imm,
  input  wire isa_pkg::access_size_e i_size,
  input  wire logic                  i_is_store,
  input  wire logic [31:0]           i_rs1_value,
  input  wire logic [31:0]           i_rs2_value,
  input  wire logic                  i_bus_dv,
  input  wire logic [31:0]           i_bus_rdata,
  output core_pkg::bus_req_t         o_bus_req,
  output isa_pkg::instr_u            o_instr,
  output logic [31:0]                o_load_data,
  output logic                       o_load_valid,
  output logic [31:0]                o_pc
);
  import isa_pkg::*;
  import core_pkg::*;

  bus_req_t    r_req;
  logic        r_fetching;       // Outstanding request is a fetch
  logic        r_boot;           // First fetch after reset
  instr_u      r_instr;
  logic [31:0] r_pc;
  logic        w_dv;

  assign w_dv = r_req.valid & i_bus_dv;    // Answer to our request

  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      r_pc <= `RESET_VECTOR;
    end else if (i_load_pc) begin
      r_pc <= r_pc + `INSTR_STEP;          // Step once per completed instr
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      r_req.valid <= 1'b0;
      r_fetching  <= 1'b0;
      r_boot      <= 1'b1;
    end else begin
      if (w_dv) begin
        r_req.valid <= 1'b0;               // Drop one cycle after dv
      end
      if (r_boot | i_start_fetch) begin
        r_boot     <= 1'b0;
        r_fetching <= 1'b1;
        r_req      <= '{valid: 1'b1, write: 1'b0, size: SZ_WORD, addr: r_pc, wdata: '0};
      end else if (i_start_mem) begin
        r_fetching  <= 1'b0;
        r_req.valid <= 1'b1;
        r_req.write <= i_is_store;
        r_req.size  <= i_size;
        r_req.addr  <= i_rs1_value + i_imm;   // Base plus offset
        r_req.wdata <= i_rs2_value;           // Ignored on loads
      end
    end
  end

  always_ff @(posedge i_clk) begin
    if (w_dv & r_fetching) begin
      r_instr <= i_bus_rdata;
    end
  end

  // Bypass on fetch dv so the decoder sees the new word in that cycle
  assign o_instr      = (w_dv & r_fetching) ? instr_u'(i_bus_rdata) : r_instr;
  assign o_load_data  = i_bus_rdata;
  assign o_load_valid = w_dv & ~r_fetching & ~r_req.write;
  assign o_bus_req    = r_req;
  assign o_pc         = r_pc;

  a_req_stable: assert property (@(posedge i_clk) disable iff (i_reset)
    r_req.valid && !i_bus_dv |=> $stable(r_req));

endmodule

`default_nettype wire

// ==== verilog/instr_decoder.sv ====
`default_nettype none

module instr_decoder (
  input  wire isa_pkg::instr_u       i_instr,
  output isa_pkg::op_e               o_op,
  output isa_pkg::op_class_e         o_class,
  output logic [31:0]                o_imm,
  output isa_pkg::access_size_e      o_size,
  output logic                       o_is_store
);
  import isa_pkg::*;

  logic w_alt;                          // SUB/SRA variant

  assign w_alt = i_instr.r.funct7 == 7'b0100000;

  always_comb begin
    o_op = OP_OTHER;
    case (i_instr.r.opcode)
      OPC_OP: begin
        if (i_instr.r.funct7 == 7'b0000001) begin
          o_op = op_e'(6'd10 + {3'b000, i_instr.r.funct3});   // MUL..REMU in funct3 order
        end else begin
          case (i_instr.r.funct3)
            3'b000:  o_op = w_alt ? OP_SUB : OP_ADD;
            3'b001:  o_op = OP_SLL;
            3'b010:  o_op = OP_SLT;
            3'b011:  o_op = OP_SLTU;
            3'b100:  o_op = OP_XOR;
            3'b101:  o_op = w_alt ? OP_SRA : OP_SRL;
            3'b110:  o_op = OP_OR;
            default: o_op = OP_AND;
          endcase
        end
      end
      OPC_LOAD: begin
        case (i_instr.i.funct3)
          3'b000:  o_op = OP_LB;
          3'b001:  o_op = OP_LH;
          3'b010:  o_op = OP_LW;
          3'b100:  o_op = OP_LBU;
          3'b101:  o_op = OP_LHU;
          default: o_op = OP_OTHER;       // Reserved widths
        endcase
      end
      OPC_STORE: begin
        case (i_instr.r.funct3)
          3'b000:  o_op = OP_SB;
          3'b001:  o_op = OP_SH;
          3'b010:  o_op = OP_SW;
          default: o_op = OP_OTHER;
        endcase
      end
      default: o_op = OP_OTHER;
    endcase
  end

  always_comb begin
    if (o_op >= OP_DIV && o_op <= OP_REMU) begin
      o_class = CLS_DIVREM;
    end else if (o_op >= OP_LB && o_op <= OP_SW) begin
      o_class = CLS_MEM;
    end else begin
      o_class = CLS_PLAIN;
    end
    case (o_op)
      OP_LB, OP_LBU, OP_SB: o_size = SZ_BYTE;
      OP_LH, OP_LHU, OP_SH: o_size = SZ_HALF;
      default:              o_size = SZ_WORD;
    endcase
  end

  assign o_is_store = (o_op >= OP_SB) && (o_op <= OP_SW);
  // S format splits the offset over funct7 and rd
  assign o_imm = o_is_store
               ? {{20{i_instr.r.funct7[6]}}, i_instr.r.funct7, i_instr.r.rd}
               : {{20{i_instr.i.imm[11]}}, i_instr.i.imm};

endmodule

`default_nettype wire

// ==== verilog/control_unit.sv ====
`default_nettype none

module control_unit (
  input  wire logic                  i_clk,
  input  wire logic                  i_reset,
  input  wire isa_pkg::op_class_e    i_class,
  input  wire logic                  i_bus_dv,
  input  wire logic                  i_div_done,
  input  wire logic                  i_m_pending,
  input  wire logic                  i_s_pending,
  input  wire logic                  i_irq_done,
  output core_pkg::ctrl_state_e      o_state,
  output logic                       o_load_pc,
  output logic                       o_start_fetch,
  output logic                       o_start_mem,
  output logic                       o_start_div,
  output logic                       o_enter_m,
  output logic                       o_enter_s
);
  import isa_pkg::*;
  import core_pkg::*;

  ctrl_state_e r_state;
  logic        r_start_fetch;
  logic        r_start_mem;
  logic        r_start_div;
  logic        w_execute;
  logic        w_complete;        // Current instruction finishes this cycle

  assign w_execute = r_state == ST_EXECUTE;

  always_comb begin
    case (i_class)
      CLS_MEM:    w_complete = w_execute & i_bus_dv;     // Data access answered
      CLS_DIVREM: w_complete = w_execute & i_div_done;
      default:    w_complete = w_execute;                // First execute cycle
    endcase
  end

  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      r_state       <= ST_FETCH;
      r_start_fetch <= 1'b0;
      r_start_mem   <= 1'b0;
      r_start_div   <= 1'b0;
    end else begin
      r_start_fetch <= 1'b0;               // Pulses by default
      r_start_mem   <= 1'b0;
      r_start_div   <= 1'b0;
      case (r_state)
        ST_FETCH: begin
          if (i_bus_dv) begin
            r_state     <= ST_EXECUTE;
            r_start_mem <= i_class == CLS_MEM;      // Class of the word just fetched
            r_start_div <= i_class == CLS_DIVREM;
          end
        end
        ST_EXECUTE: begin
          if (w_complete) begin
            if (i_m_pending) begin
              r_state <= ST_MINT;          // Machine wins
            end else if (i_s_pending) begin
              r_state <= ST_SINT;
            end else begin
              r_state       <= ST_FETCH;
              r_start_fetch <= 1'b1;
            end
          end
        end
        default: begin                     // MINT or SINT
          if (i_irq_done) begin
            r_state       <= ST_FETCH;     // PC already stepped at completion
            r_start_fetch <= 1'b1;
          end
        end
      endcase
    end
  end

  assign o_state       = r_state;
  assign o_load_pc     = w_complete;
  assign o_start_fetch = r_start_fetch;
  assign o_start_mem   = r_start_mem;
  assign o_start_div   = r_start_div;
  assign o_enter_m     = w_complete & i_m_pending;
  assign o_enter_s     = w_complete & ~i_m_pending & i_s_pending;

  // Divider completion only while a divide waits in execute
  a_done_in_execute: assert property (@(posedge i_clk) disable iff (i_reset)
    i_div_done |-> r_state == ST_EXECUTE && i_class == CLS_DIVREM);

endmodule

`default_nettype wire

// ==== verilog/div_rem_unit.sv ====
`default_nettype none

`include "seq_config.svh"

module div_rem_unit (
  input  wire logic                  i_clk,
  input  wire logic                  i_reset,
  input  wire logic                  i_start,
  input  wire isa_pkg::op_e          i_op,
  input  wire logic [31:0]           i_dividend,
  input  wire logic [31:0]           i_divisor,
  output logic                       o_done,
  output logic [31:0]                o_result,
  output logic                       o_busy
);
  import isa_pkg::*;

  localparam int CNT_W = $clog2(`DIV_CYCLES + 1);

  logic             w_signed;
  logic             w_a_neg;
  logic             w_b_neg;
  logic [31:0]      w_abs_a;
  logic [31:0]      w_abs_b;
  logic [32:0]      w_shift;       // Partial remainder with next dividend bit
  logic [32:0]      w_diff;
  logic [CNT_W-1:0] r_count;       // Steps left
  logic             r_done;
  logic [31:0]      r_quot;        // Dividend shifts out, quotient shifts in
  logic [31:0]      r_rem;
  logic [31:0]      r_divisor;
  logic             r_q_neg;
  logic             r_r_neg;
  logic             r_want_rem;

  assign w_signed = (i_op == OP_DIV) | (i_op == OP_REM);
  assign w_a_neg  = w_signed & i_dividend[31];
  assign w_b_neg  = w_signed & i_divisor[31];
  assign w_abs_a  = w_a_neg ? -i_dividend : i_dividend;   // -2^31 stays 0x8000_0000
  assign w_abs_b  = w_b_neg ? -i_divisor : i_divisor;
  assign w_shift  = {r_rem, r_quot[31]};
  assign w_diff   = w_shift - {1'b0, r_divisor};

  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      r_count <= '0;
      r_done  <= 1'b0;
    end else begin
      r_done <= 1'b0;
      if (i_start) begin
        r_count    <= CNT_W'(`DIV_CYCLES);
        r_quot     <= w_abs_a;
        r_rem      <= '0;
        r_divisor  <= w_abs_b;
        r_q_neg    <= (w_a_neg ^ w_b_neg) & (i_divisor != '0);   // x/0 stays all ones
        r_r_neg    <= w_a_neg;                                   // Remainder takes dividend sign
        r_want_rem <= (i_op == OP_REM) | (i_op == OP_REMU);
      end else if (o_busy) begin
        r_count <= r_count - 1'b1;
        r_done  <= r_count == CNT_W'(1);
        if (!w_diff[32]) begin
          r_rem  <= w_diff[31:0];                  // Divisor fits
          r_quot <= {r_quot[30:0], 1'b1};
        end else begin
          r_rem  <= w_shift[31:0];                 // Restore
          r_quot <= {r_quot[30:0], 1'b0};
        end
      end
    end
  end

  assign o_busy   = r_count != '0;
  assign o_done   = r_done;
  assign o_result = r_want_rem ? (r_r_neg ? -r_rem : r_rem)
                               : (r_q_neg ? -r_quot : r_quot);

  a_no_restart: assert property (@(posedge i_clk) disable iff (i_reset)
    i_start |-> !o_busy);

endmodule

`default_nettype wire

// ==== verilog/trap_unit.sv ====
`default_nettype none

module trap_unit (
  input  wire logic                  i_clk,
  input  wire logic                  i_reset,
  input  wire logic                  i_m_irq,
  input  wire logic                  i_s_irq,
  input  wire logic                  i_enter_m,
  input  wire logic                  i_enter_s,
  output logic                       o_m_pending,
  output logic                       o_s_pending,
  output core_pkg::trap_cause_t      o_cause
);
  import core_pkg::*;

  logic        r_m_pend;
  logic        r_s_pend;
  trap_cause_t r_cause;

  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      r_m_pend <= 1'b0;
      r_s_pend <= 1'b0;
      r_cause  <= '0;
    end else begin
      r_m_pend      <= i_m_irq | (r_m_pend & ~i_enter_m);   // New strobe beats clear
      r_s_pend      <= i_s_irq | (r_s_pend & ~i_enter_s);
      r_cause.taken <= i_enter_m | i_enter_s;
      if (i_enter_m | i_enter_s) begin
        r_cause.machine    <= i_enter_m;       // Hold until next entry
        r_cause.supervisor <= i_enter_s;
      end
    end
  end

  assign o_m_pending = r_m_pend;
  assign o_s_pending = r_s_pend;
  assign o_cause     = r_cause;

  a_one_entry: assert property (@(posedge i_clk) disable iff (i_reset)
    !(i_enter_m && i_enter_s));

endmodule

`default_nettype wire

// ==== verilog/rv_sequencer.sv ====
`default_nettype none

module rv_sequencer (
  input  wire logic                  i_clk,
  input  wire logic                  i_reset,
  input  wire logic [31:0]           i_rs1_value,
  input  wire logic [31:0]           i_rs2_value,
  input  wire logic                  i_m_irq,
  input  wire logic                  i_s_irq,
  input  wire logic                  i_irq_done,
  input  wire logic                  i_bus_dv,
  input  wire logic [31:0]           i_bus_rdata,
  output core_pkg::bus_req_t         o_bus_req,
  output logic [31:0]                o_load_data,
  output logic                       o_load_valid,
  output logic [31:0]                o_div_result,
  output logic                       o_div_valid,
  output core_pkg::trap_cause_t      o_trap_cause,
  output core_pkg::ctrl_state_e      o_state,
  output logic [31:0]                o_pc
);
  import isa_pkg::*;

  instr_u       w_instr;
  op_e          w_op;
  op_class_e    w_class;
  logic [31:0]  w_imm;
  access_size_e w_size;
  logic         w_is_store;
  logic         w_load_pc;
  logic         w_start_fetch;
  logic         w_start_mem;
  logic         w_start_div;
  logic         w_m_pending;
  logic         w_s_pending;
  logic         w_enter_m;
  logic         w_enter_s;

  mem_port u_mem_port (
    .i_clk(i_clk), .i_reset(i_reset),
    .i_start_fetch(w_start_fetch), .i_start_mem(w_start_mem), .i_load_pc(w_load_pc),
    .i_imm(w_imm), .i_size(w_size), .i_is_store(w_is_store),
    .i_rs1_value(i_rs1_value), .i_rs2_value(i_rs2_value),
    .i_bus_dv(i_bus_dv), .i_bus_rdata(i_bus_rdata), .o_bus_req(o_bus_req),
    .o_instr(w_instr), .o_load_data(o_load_data), .o_load_valid(o_load_valid),
    .o_pc(o_pc)
  );

  instr_decoder u_instr_decoder (
    .i_instr(w_instr), .o_op(w_op), .o_class(w_class),
    .o_imm(w_imm), .o_size(w_size), .o_is_store(w_is_store)
  );

  control_unit u_control_unit (
    .i_clk(i_clk), .i_reset(i_reset), .i_class(w_class),
    .i_bus_dv(i_bus_dv), .i_div_done(o_div_valid),
    .i_m_pending(w_m_pending), .i_s_pending(w_s_pending), .i_irq_done(i_irq_done),
    .o_state(o_state), .o_load_pc(w_load_pc), .o_start_fetch(w_start_fetch),
    .o_start_mem(w_start_mem), .o_start_div(w_start_div),
    .o_enter_m(w_enter_m), .o_enter_s(w_enter_s)
  );

  div_rem_unit u_div_rem_unit (
    .i_clk(i_clk), .i_reset(i_reset), .i_start(w_start_div), .i_op(w_op),
    .i_dividend(i_rs1_value), .i_divisor(i_rs2_value),
    .o_done(o_div_valid), .o_result(o_div_result), .o_busy()
  );

  trap_unit u_trap_unit (
    .i_clk(i_clk), .i_reset(i_reset), .i_m_irq(i_m_irq), .i_s_irq(i_s_irq),
    .i_enter_m(w_enter_m), .i_enter_s(w_enter_s),
    .o_m_pending(w_m_pending), .o_s_pending(w_s_pending), .o_cause(o_trap_cause)
  );

endmodule

`default_nettype wire

// ==== test/tb_clock_gen.sv ====
`default_nettype none

module tb_clock_gen (
  output logic o_clk,
  output logic o_reset
);
  timeunit 1ns;
  timeprecision 100ps;

  initial begin
    o_clk = 1'b0;
    forever #5 o_clk = ~o_clk;        // 10 ns period
  end

  initial begin
    o_reset = 1'b1;
    repeat (10) @(posedge o_clk);     // Hold for 10 cycles
    @(negedge o_clk);
    o_reset = 1'b0;
  end

endmodule

`default_nettype wire

// ==== test/tb_checker.sv ====
`default_nettype none

`include "seq_config.svh"

module tb_checker (
  input  wire logic                  i_clk,
  input  wire logic                  i_reset,
  input  wire core_pkg::bus_req_t    i_bus_req,
  input  wire logic                  i_bus_dv,
  input  wire logic [31:0]           i_load_data,
  input  wire logic                  i_load_valid,
  input  wire logic [31:0]           i_div_result,
  input  wire logic                  i_div_valid,
  input  wire core_pkg::trap_cause_t i_trap_cause,
  input  wire core_pkg::ctrl_state_e i_state,
  input  wire logic [31:0]           i_exp_fetch_addr,
  input  wire logic [1:0]            i_exp_kind,
  input  wire logic [31:0]           i_exp_addr,
  input  wire logic [1:0]            i_exp_size,
  input  wire logic [31:0]           i_exp_wdata,
  input  wire logic [31:0]           i_exp_load_data,
  input  wire logic [31:0]           i_exp_div,
  input  wire logic [1:0]            i_exp_trap,
  output int                         o_errors,
  output int                         o_checks
);
  timeunit 1ns;
  timeprecision 100ps;
  import core_pkg::*;

  localparam logic [1:0] K_LOAD  = 2'd1;
  localparam logic [1:0] K_STORE = 2'd2;
  localparam logic [1:0] K_DIV   = 2'd3;

  bus_req_t    r_prev_req;                 // Request seen last cycle
  logic        r_prev_dv;
  logic        r_prev_reset;
  ctrl_state_e r_prev_state;
  int          r_exec_edges;               // Edges since execute was entered

  initial begin
    o_errors     = 0;
    o_checks     = 0;
    r_prev_req   = '0;
    r_prev_dv    = 1'b0;
    r_prev_reset = 1'b1;
    r_prev_state = ST_FETCH;
    r_exec_edges = 0;
  end

  task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
    o_checks++;
    if (got !== exp) begin
      o_errors++;
      $display("[FAIL] %0t %s got 0x%h expected 0x%h", $time, name, got, exp);
    end
  endtask

  task automatic report(input string what);
    o_errors++;
    $display("%0t Error: %s", $time, what);
  endtask

  always @(posedge i_clk) begin
    if (i_state == ST_EXECUTE) begin
      r_exec_edges = (r_prev_state == ST_EXECUTE) ? r_exec_edges + 1 : 0;   // 0 in first cycle
    end
    if (!i_reset) begin
      if (r_prev_reset) begin                            // First cycle out of reset
        check_value("o_bus_req.valid", i_bus_req.valid, 32'h0);
        check_value("o_load_valid", i_load_valid, 32'h0);
        check_value("o_div_valid", i_div_valid, 32'h0);
        check_value("o_trap_cause.taken", i_trap_cause.taken, 32'h0);
      end
      if (r_prev_req.valid && !r_prev_dv && i_bus_req !== r_prev_req) begin
        report("bus request changed while waiting for dv");
      end
      if (i_bus_req.valid && !r_prev_req.valid) begin    // New request
        if (i_state == ST_FETCH) begin
          check_value("o_bus_req.addr", i_bus_req.addr, i_exp_fetch_addr);
          check_value("o_bus_req.write", i_bus_req.write, 32'h0);
          check_value("o_bus_req.size", i_bus_req.size, 32'd2);
        end else if (i_exp_kind == K_LOAD || i_exp_kind == K_STORE) begin
          check_value("o_bus_req.addr", i_bus_req.addr, i_exp_addr);
          check_value("o_bus_req.size", i_bus_req.size, i_exp_size);
          check_value("o_bus_req.write", i_bus_req.write, i_exp_kind == K_STORE);
          if (i_exp_kind == K_STORE) begin
            check_value("o_bus_req.wdata", i_bus_req.wdata, i_exp_wdata);
          end
        end else begin
          report("data request for an instruction without memory access");
        end
      end
      if (i_state == ST_EXECUTE && i_bus_dv) begin     // Data access answered
        check_value("o_load_valid", i_load_valid, i_exp_kind == K_LOAD);
      end else if (i_load_valid) begin
        report("load data strobe outside a data access");
      end
      if (i_load_valid) begin
        check_value("o_load_data", i_load_data, i_exp_load_data);
      end
      if (i_div_valid) begin
        if (i_exp_kind != K_DIV) report("divide result strobe without a divide");
        check_value("o_div_result", i_div_result, i_exp_div);
        check_value("o_div_valid latency", r_exec_edges, `DIV_CYCLES + 1);
      end
      if (r_prev_state == ST_EXECUTE && (i_state == ST_MINT || i_state == ST_SINT)) begin
        check_value("o_trap_cause.taken", i_trap_cause.taken, 32'h1);   // Entry pulse
      end
      if (i_trap_cause.taken) begin
        if (i_exp_trap == 2'd0) begin
          report("interrupt entry where none was expected");
        end else begin
          check_value("o_trap_cause.machine", i_trap_cause.machine, i_exp_trap == 2'd1);
          check_value("o_trap_cause.supervisor", i_trap_cause.supervisor, i_exp_trap == 2'd2);
        end
      end
    end
    r_prev_req   = i_bus_req;
    r_prev_dv    = i_bus_dv;
    r_prev_reset = i_reset;
    r_prev_state = i_state;
  end

endmodule

`default_nettype wire

// ==== test/tb_rv_sequencer.sv ====
`default_nettype none

`include "seq_config.svh"

module tb_rv_sequencer;
  timeunit 1ns;
  timeprecision 100ps;
  import isa_pkg::*;
  import core_pkg::*;

  localparam int NUM_ROWS   = 19;
  localparam int WAIT_LIMIT = 300;         // Cycles per wait
  localparam logic [1:0] K_PLAIN = 2'd0;
  localparam logic [1:0] K_LOAD  = 2'd1;
  localparam logic [1:0] K_STORE = 2'd2;
  localparam logic [1:0] K_DIV   = 2'd3;

  typedef struct packed {
    logic [1:0]  kind;
    logic [31:0] instr;
    logic [11:0] imm;
    logic [1:0]  size;
    logic [31:0] rs1;
    logic [31:0] rs2;
    logic [31:0] load_data;                // Responder answer for loads
    logic [31:0] exp_div;
    logic        m_irq;
    logic        s_irq;
    logic [1:0]  trap;                     // 1 machine, 2 supervisor
  } row_t;

  row_t        rows [NUM_ROWS];
  int          row_idx;
  logic [31:0] lfsr;
  logic        clk, reset;
  logic [31:0] rs1, rs2, bus_rdata;
  logic        m_irq, s_irq, irq_done, bus_dv;
  bus_req_t    bus_req;
  logic [31:0] load_data, div_result, pc;
  logic        load_valid, div_valid;
  trap_cause_t trap_cause;
  ctrl_state_e state;
  logic [31:0] exp_fetch_addr, exp_addr, exp_wdata, exp_load_data, exp_div;
  logic [1:0]  exp_kind, exp_size, exp_trap;
  int          errors, checks;
  logic        ok;

  tb_clock_gen u_clock_gen (.o_clk(clk), .o_reset(reset));

  rv_sequencer DUT (
    .i_clk(clk), .i_reset(reset), .i_rs1_value(rs1), .i_rs2_value(rs2),
    .i_m_irq(m_irq), .i_s_irq(s_irq), .i_irq_done(irq_done),
    .i_bus_dv(bus_dv), .i_bus_rdata(bus_rdata), .o_bus_req(bus_req),
    .o_load_data(load_data), .o_load_valid(load_valid),
    .o_div_result(div_result), .o_div_valid(div_valid),
    .o_trap_cause(trap_cause), .o_state(state), .o_pc(pc)
  );

  tb_checker u_checker (
    .i_clk(clk), .i_reset(reset), .i_bus_req(bus_req), .i_bus_dv(bus_dv),
    .i_load_data(load_data), .i_load_valid(load_valid),
    .i_div_result(div_result), .i_div_valid(div_valid),
    .i_trap_cause(trap_cause), .i_state(state), .i_exp_fetch_addr(exp_fetch_addr),
    .i_exp_kind(exp_kind), .i_exp_addr(exp_addr), .i_exp_size(exp_size),
    .i_exp_wdata(exp_wdata), .i_exp_load_data(exp_load_data), .i_exp_div(exp_div),
    .i_exp_trap(exp_trap), .o_errors(errors), .o_checks(checks)
  );

  // RV32 encodings with rd=x2, rs1=x1, rs2=x3
  function automatic logic [31:0] encode(input logic [1:0] kind, input logic [2:0] f3,
                                         input logic [11:0] imm);
    case (kind)
      K_LOAD:  return {imm, 5'd1, f3, 5'd2, 7'b0000011};
      K_STORE: return {imm[11:5], 5'd3, 5'd1, f3, imm[4:0], 7'b0100011};
      K_DIV:   return {7'b0000001, 5'd3, 5'd1, f3, 5'd2, 7'b0110011};
      default: return {7'b0000000, 5'd3, 5'd1, 3'b000, 5'd2, 7'b0110011};   // ADD
    endcase
  endfunction

  function automatic row_t make_row(input logic [1:0] kind, input logic [2:0] f3,
                                    input logic [11:0] imm, input logic [31:0] a,
                                    input logic [31:0] b, input logic [31:0] ld,
                                    input logic [31:0] q, input logic m, input logic s,
                                    input logic [1:0] trap);
    row_t r;
    r = '{kind: kind, instr: encode(kind, f3, imm), imm: imm, size: f3[1:0], rs1: a,
          rs2: b, load_data: ld, exp_div: q, m_irq: m, s_irq: s, trap: trap};
    return r;
  endfunction

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);      // Galois form
  endfunction

  task automatic draw_delay(output int d);
    d = 0;
    repeat (3) begin                       // One step per bit
      lfsr = lfsr_next(lfsr);
      d    = (d << 1) | lfsr[0];
    end
  endtask

  initial begin
    rows[0]  = make_row(K_PLAIN, 3'd0, 12'h000, 32'd1, 32'd2, 0, 0, 0, 0, 0);
    rows[1]  = make_row(K_LOAD, 3'd2, 12'h010, 32'h2000, 0, 32'hdead_beef, 0, 0, 0, 0);
    rows[2]  = make_row(K_STORE, 3'd0, 12'hffc, 32'h3000, 32'h55, 0, 0, 0, 0, 0);
    rows[3]  = make_row(K_DIV, 3'd4, 0, 32'd100, 32'd7, 0, 32'h0000_000e, 0, 0, 0);
    rows[4]  = make_row(K_DIV, 3'd5, 0, 32'hffff_fffe, 32'd2, 0, 32'h7fff_ffff, 0, 0, 0);
    rows[5]  = make_row(K_DIV, 3'd6, 0, 32'hffff_fff9, 32'd2, 0, 32'hffff_ffff, 0, 0, 0);
    rows[6]  = make_row(K_DIV, 3'd7, 0, 32'd100, 32'd7, 0, 32'h0000_0002, 0, 0, 0);
    rows[7]  = make_row(K_DIV, 3'd4, 0, 32'd5, 32'd0, 0, 32'hffff_ffff, 0, 0, 0);   // x/0
    rows[8]  = make_row(K_DIV, 3'd6, 0, 32'd5, 32'd0, 0, 32'h0000_0005, 0, 0, 0);
    rows[9]  = make_row(K_DIV, 3'd4, 0, 32'h8000_0000, 32'hffff_ffff, 0, 32'h8000_0000, 0, 0, 0);
    rows[10] = make_row(K_DIV, 3'd6, 0, 32'h8000_0000, 32'hffff_ffff, 0, 32'h0, 0, 0, 0);
    rows[11] = make_row(K_LOAD, 3'd1, 12'h7ff, 32'h100, 0, 32'h0000_1234, 0, 0, 0, 0);
    rows[12] = make_row(K_STORE, 3'd1, 12'h020, 32'h500, 32'habcd, 0, 0, 0, 0, 0);
    rows[13] = make_row(K_PLAIN, 3'd0, 0, 32'd3, 32'd4, 0, 0, 1, 0, 2'd1);
    rows[14] = make_row(K_PLAIN, 3'd0, 0, 32'd5, 32'd6, 0, 0, 1, 1, 2'd1);   // Both pending
    rows[15] = make_row(K_PLAIN, 3'd0, 0, 32'd7, 32'd8, 0, 0, 0, 0, 2'd2);   // Held supervisor
    rows[16] = make_row(K_LOAD, 3'd4, 12'h801, 32'h4000, 0, 32'h0000_00ff, 0, 0, 1, 2'd2);
    rows[17] = make_row(K_DIV, 3'd4, 0, 32'd100, 32'd7, 0, 32'h0000_000e, 1, 0, 2'd1);
    rows[18] = make_row(K_STORE, 3'd2, 12'h000, 32'h600, 32'h1234_5678, 0, 0, 0, 0, 0);
  end

  // Bus memory model with random latency
  initial begin : bus_responder
    int delay;
    int idx;
    forever begin
      @(negedge clk);
      if (bus_req.valid) begin
        draw_delay(delay);
        repeat (delay) @(negedge clk);
        if (state == ST_FETCH) begin
          idx       = (bus_req.addr - `RESET_VECTOR) / `INSTR_STEP;
          bus_rdata = (idx < NUM_ROWS) ? rows[idx].instr : 32'h0;
        end else begin
          bus_rdata = bus_req.write ? 32'h0 : rows[row_idx].load_data;
        end
        bus_dv = 1'b1;
        @(negedge clk);
        bus_dv = 1'b0;
      end
    end
  end

  task automatic wait_pc(input logic [31:0] target, inout logic pass);
    int n;
    n = 0;
    while (pc !== target && n < WAIT_LIMIT) begin
      @(negedge clk);
      n++;
    end
    if (pc !== target) begin
      $display("Timeout: PC never reached 0x%h", target);
      pass = 1'b0;
    end
  endtask

  task automatic wait_state(input ctrl_state_e target, inout logic pass);
    int n;
    n = 0;
    while (state !== target && n < WAIT_LIMIT) begin
      @(negedge clk);
      n++;
    end
    if (state !== target) begin
      $display("Timeout: interrupt state %s never entered", target.name());
      pass = 1'b0;
    end
  endtask

  task automatic apply_row(input int i, inout logic pass);
    @(negedge clk);
    row_idx        = i;
    rs1            = rows[i].rs1;
    rs2            = rows[i].rs2;
    m_irq          = rows[i].m_irq;
    s_irq          = rows[i].s_irq;
    exp_fetch_addr = `RESET_VECTOR + `INSTR_STEP * i;
    exp_kind       = rows[i].kind;
    exp_addr       = rows[i].rs1 + {{20{rows[i].imm[11]}}, rows[i].imm};
    exp_size       = rows[i].size;
    exp_wdata      = rows[i].rs2;
    exp_load_data  = rows[i].load_data;
    exp_div        = rows[i].exp_div;
    exp_trap       = rows[i].trap;
    @(negedge clk);
    m_irq = 1'b0;
    s_irq = 1'b0;
    wait_pc(`RESET_VECTOR + `INSTR_STEP * (i + 1), pass);
    if (pass && rows[i].trap != 2'd0) begin
      wait_state(rows[i].trap == 2'd1 ? ST_MINT : ST_SINT, pass);
      @(negedge clk);
      irq_done = 1'b1;                     // End of service
      @(negedge clk);
      irq_done = 1'b0;
    end
  endtask

  initial begin : main
    int n;
    lfsr     = 32'hc443;
    row_idx  = 0;
    rs1      = '0;
    rs2      = '0;
    m_irq    = 1'b0;
    s_irq    = 1'b0;
    irq_done = 1'b0;
    bus_dv   = 1'b0;
    bus_rdata = '0;
    exp_fetch_addr = `RESET_VECTOR;
    {exp_kind, exp_size, exp_trap} = '0;
    {exp_addr, exp_wdata, exp_load_data, exp_div} = '0;
    ok = 1'b1;
    n  = 0;
    while (reset !== 1'b0 && n < WAIT_LIMIT) begin
      @(posedge clk);
      n++;
    end
    if (reset !== 1'b0) begin
      $display("Timeout: reset was never released");
      ok = 1'b0;
    end
    for (int i = 0; i < NUM_ROWS && ok; i++) begin
      apply_row(i, ok);
    end
    @(negedge clk);
    exp_fetch_addr = `RESET_VECTOR + `INSTR_STEP * NUM_ROWS;   // Fetch after the last row
    repeat (3) @(negedge clk);
    $display("Checks: %0d, errors: %0d", checks, errors);
    if (ok && errors == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== rv_sequencer.f ====
+incdir+verilog
verilog/isa_pkg.sv
verilog/core_pkg.sv
verilog/mem_port.sv
verilog/instr_decoder.sv
verilog/control_unit.sv
verilog/div_rem_unit.sv
verilog/trap_unit.sv
verilog/rv_sequencer.sv
test/tb_clock_gen.sv
test/tb_checker.sv
test/tb_rv_sequencer.sv

// ==== Bender.yml ====
package:
  name: rv_sequencer

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/isa_pkg.sv
      - verilog/core_pkg.sv
      - verilog/mem_port.sv
      - verilog/instr_decoder.sv
      - verilog/control_unit.sv
      - verilog/div_rem_unit.sv
      - verilog/trap_unit.sv
      - verilog/rv_sequencer.sv
  - target: test
    include_dirs:
      - verilog
    files:
      - test/tb_clock_gen.sv
      - test/tb_checker.sv
      - test/tb_rv_sequencer.sv
